/* src/lc4_pkg.sv */
// --------------------
// lc4 shared types
// --------------------
package lc4_pkg;

   localparam int word_w    = 16;  // data and instruction width
   localparam int reg_sel_w = 3;   // eight registers

   typedef logic [word_w-1:0]    word_t;
   typedef logic [reg_sel_w-1:0] reg_sel_t;
   typedef logic [2:0]           nzp_t;  // {n, z, p}

   localparam word_t reset_pc = 16'h8200;  // boot address

   // top four bits of the instruction word, kept subset only
   typedef enum logic [3:0] {
      op_br    = 4'b0000,
      op_arith = 4'b0001,  // add, sub, add imm
      op_logic = 4'b0101,  // and only
      op_ldr   = 4'b0110,
      op_str   = 4'b0111,
      op_const = 4'b1001
   } opcode_e;

   typedef enum logic [2:0] {
      alu_add       = 3'd0,
      alu_sub       = 3'd1,
      alu_and       = 3'd2,
      alu_addi      = 3'd3,  // rs + sext(imm5)
      alu_const     = 3'd4,  // sext(imm9)
      alu_addr      = 3'd5,  // rs + sext(imm6), ldr/str
      alu_br_target = 3'd6   // pc + 1 + sext(imm9)
   } alu_op_e;

   // decoded control, all zero is a bubble
   typedef struct packed {
      alu_op_e  alu_op;
      reg_sel_t rs;
      reg_sel_t rt;
      reg_sel_t rd;
      logic     rs_re;
      logic     rt_re;
      logic     regfile_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
      logic     valid;  // clear for bubbles and nops
   } ctrl_t;

endpackage

/* src/lc4_fwd_if.sv */
// --------------------
// bypass paths to X
// --------------------
interface lc4_fwd_if;

   lc4_pkg::reg_sel_t m_rd;    // dest of insn in M
   logic              m_we;    // M result is forwardable
   lc4_pkg::word_t    m_data;  // alu result in M
   lc4_pkg::reg_sel_t w_rd;
   logic              w_we;
   lc4_pkg::word_t    w_data;  // final writeback value

   modport src (output m_rd, m_we, m_data, w_rd, w_we, w_data);

   modport exec (input m_rd, m_we, m_data, w_rd, w_we, w_data);

endinterface

/* src/lc4_decoder.sv */
// --------------------
// lc4 decoder
// --------------------
module lc4_decoder (
   input  lc4_pkg::word_t i_insn,
   output lc4_pkg::ctrl_t o_ctrl
);

   lc4_pkg::opcode_e opcode;

   assign opcode = lc4_pkg::opcode_e'(i_insn[15:12]);

   always_comb begin
      o_ctrl    = '0;              // nop unless matched below
      o_ctrl.rd = i_insn[11:9];
      o_ctrl.rs = i_insn[8:6];
      o_ctrl.rt = i_insn[2:0];
      case (opcode)
         lc4_pkg::op_br: begin
            if (i_insn[11:9] != 3'b000) begin  // nzp of zero is the nop word
               o_ctrl.alu_op    = lc4_pkg::alu_br_target;
               o_ctrl.is_branch = 1'b1;
               o_ctrl.valid     = 1'b1;
            end
         end
         lc4_pkg::op_arith: begin
            if (i_insn[5]) begin
               o_ctrl.alu_op     = lc4_pkg::alu_addi;
               o_ctrl.rs_re      = 1'b1;
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.valid      = 1'b1;
            end else if (i_insn[5:3] == 3'b000 || i_insn[5:3] == 3'b010) begin
               o_ctrl.alu_op     = (i_insn[4]) ? lc4_pkg::alu_sub : lc4_pkg::alu_add;
               o_ctrl.rs_re      = 1'b1;
               o_ctrl.rt_re      = 1'b1;
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.valid      = 1'b1;
            end
         end
         lc4_pkg::op_logic: begin
            if (i_insn[5:3] == 3'b000) begin  // only register and is kept
               o_ctrl.alu_op     = lc4_pkg::alu_and;
               o_ctrl.rs_re      = 1'b1;
               o_ctrl.rt_re      = 1'b1;
               o_ctrl.regfile_we = 1'b1;
               o_ctrl.valid      = 1'b1;
            end
         end
         lc4_pkg::op_ldr: begin
            o_ctrl.alu_op     = lc4_pkg::alu_addr;
            o_ctrl.rs_re      = 1'b1;
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.is_load    = 1'b1;
            o_ctrl.valid      = 1'b1;
         end
         lc4_pkg::op_str: begin
            o_ctrl.alu_op   = lc4_pkg::alu_addr;
            o_ctrl.rt       = i_insn[11:9];  // store data sits in the rd field
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
            o_ctrl.valid    = 1'b1;
         end
         lc4_pkg::op_const: begin
            o_ctrl.alu_op     = lc4_pkg::alu_const;
            o_ctrl.regfile_we = 1'b1;
            o_ctrl.valid      = 1'b1;
         end
         default: o_ctrl.valid = 1'b0;  // everything else is a nop
      endcase
   end

endmodule

/* src/lc4_regfile.sv */
// --------------------
// register file
// --------------------
module lc4_regfile (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::reg_sel_t i_rs,
   input  lc4_pkg::reg_sel_t i_rt,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data,
   input  lc4_pkg::reg_sel_t i_rd,
   input  logic              i_rd_we,
   input  lc4_pkg::word_t    i_wdata
);

   lc4_pkg::word_t regs [2**lc4_pkg::reg_sel_w];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 2**lc4_pkg::reg_sel_w; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // write-through, W result seen by D in the same cycle
   assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

/* src/lc4_alu.sv */
// --------------------
// lc4 alu
// --------------------
module lc4_alu (
   input  lc4_pkg::alu_op_e i_op,
   input  lc4_pkg::word_t   i_insn,
   input  lc4_pkg::word_t   i_pc,
   input  lc4_pkg::word_t   i_rs_data,
   input  lc4_pkg::word_t   i_rt_data,
   output lc4_pkg::word_t   o_result
);

   lc4_pkg::word_t imm5;
   lc4_pkg::word_t imm6;
   lc4_pkg::word_t imm9;

   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};  // add imm
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};  // ldr/str offset
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};   // const and branch offset

   always_comb begin
      case (i_op)
         lc4_pkg::alu_add:       o_result = i_rs_data + i_rt_data;
         lc4_pkg::alu_sub:       o_result = i_rs_data - i_rt_data;
         lc4_pkg::alu_and:       o_result = i_rs_data & i_rt_data;
         lc4_pkg::alu_addi:      o_result = i_rs_data + imm5;
         lc4_pkg::alu_const:     o_result = imm9;
         lc4_pkg::alu_addr:      o_result = i_rs_data + imm6;
         lc4_pkg::alu_br_target: o_result = i_pc + 16'd1 + imm9;
         default:                o_result = '0;
      endcase
   end

endmodule

/* src/lc4_fetch.sv */
// --------------------
// fetch stage
// --------------------
module lc4_fetch #(
   parameter lc4_pkg::word_t p_reset_pc = lc4_pkg::reset_pc
) (
   input  logic           gwe,
   input  logic           i_rst_n,
   input  logic           i_stall,      // load-use hold
   input  logic           i_flush,      // taken branch in X
   input  lc4_pkg::word_t i_br_target,
   input  lc4_pkg::word_t i_cur_insn,   // imem read data
   output lc4_pkg::word_t o_cur_pc,
   output lc4_pkg::word_t o_d_insn,
   output lc4_pkg::word_t o_d_pc
);

   lc4_pkg::word_t pc_q;
   lc4_pkg::word_t pc_plus1;
   lc4_pkg::word_t d_insn_q;
   lc4_pkg::word_t d_pc_q;

   assign pc_plus1 = pc_q + 16'd1;

   // branch wins over stall
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc_q     <= p_reset_pc;
         d_insn_q <= '0;           // zero word decodes as a bubble
      end else if (i_flush) begin
         pc_q     <= i_br_target;
         d_insn_q <= '0;           // squash the wrong-path fetch
      end else if (!i_stall) begin
         pc_q     <= pc_plus1;
         d_insn_q <= i_cur_insn;
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_stall) begin
         d_pc_q <= pc_q;  // pc of the insn now in D
      end
   end

   assign o_cur_pc = pc_q;
   assign o_d_insn = d_insn_q;
   assign o_d_pc   = d_pc_q;

endmodule

/* src/lc4_execute.sv */
// --------------------
// execute stage
// --------------------
module lc4_execute (
   input  logic           gwe,
   input  logic           i_rst_n,
   input  lc4_pkg::ctrl_t i_d_ctrl,
   input  lc4_pkg::word_t i_d_insn,
   input  lc4_pkg::word_t i_d_pc,
   input  lc4_pkg::word_t i_rs_data,        // regfile, WD already applied
   input  lc4_pkg::word_t i_rt_data,
   input  lc4_pkg::word_t i_cur_dmem_data,  // load data in M, for nzp
   lc4_fwd_if.exec        fwd,
   output logic           o_stall,
   output logic           o_flush,
   output lc4_pkg::word_t o_br_target,
   output lc4_pkg::ctrl_t o_x_ctrl,
   output lc4_pkg::word_t o_x_insn,
   output lc4_pkg::word_t o_x_pc,
   output lc4_pkg::word_t o_x_result,
   output lc4_pkg::word_t o_x_rt_data
);

   lc4_pkg::ctrl_t x_ctrl_q;
   lc4_pkg::word_t x_insn_q;
   lc4_pkg::word_t x_pc_q;
   lc4_pkg::word_t x_rs_q;
   lc4_pkg::word_t x_rt_q;
   lc4_pkg::word_t rs_byp;
   lc4_pkg::word_t rt_byp;
   lc4_pkg::word_t alu_result;
   lc4_pkg::nzp_t  nzp_q;
   logic           m_load_q;  // a load now sits in M
   logic           load_use;
   logic           br_taken;

   function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t value);
      if (value == '0) return 3'b010;
      else if (value[15]) return 3'b100;
      else return 3'b001;
   endfunction

   // D/X register, bubble on stall or flush
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         x_ctrl_q <= '0;
      end else if (o_stall || o_flush) begin
         x_ctrl_q <= '0;
      end else begin
         x_ctrl_q <= i_d_ctrl;
      end
   end

   always_ff @(posedge gwe) begin
      x_insn_q <= i_d_insn;
      x_pc_q   <= i_d_pc;
      x_rs_q   <= i_rs_data;
      x_rt_q   <= i_rt_data;
   end

   // MX first, then WX
   always_comb begin
      if (fwd.m_we && fwd.m_rd == x_ctrl_q.rs) rs_byp = fwd.m_data;
      else if (fwd.w_we && fwd.w_rd == x_ctrl_q.rs) rs_byp = fwd.w_data;
      else rs_byp = x_rs_q;
      if (fwd.m_we && fwd.m_rd == x_ctrl_q.rt) rt_byp = fwd.m_data;
      else if (fwd.w_we && fwd.w_rd == x_ctrl_q.rt) rt_byp = fwd.w_data;
      else rt_byp = x_rt_q;
   end

   lc4_alu i_lc4_alu (
      .i_op      (x_ctrl_q.alu_op),
      .i_insn    (x_insn_q),
      .i_pc      (x_pc_q),
      .i_rs_data (rs_byp),
      .i_rt_data (rt_byp),
      .o_result  (alu_result)
   );

   // alu writer in X is younger than a load in M
   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         nzp_q    <= 3'b010;
         m_load_q <= 1'b0;
      end else begin
         m_load_q <= x_ctrl_q.is_load;
         if (x_ctrl_q.regfile_we && !x_ctrl_q.is_load) nzp_q <= nzp_of(alu_result);
         else if (m_load_q) nzp_q <= nzp_of(i_cur_dmem_data);
      end
   end

   assign br_taken = x_ctrl_q.is_branch && |(x_insn_q[11:9] & nzp_q);

   // store data through rt is fixed later by the WM path, so no stall there
   assign load_use = x_ctrl_q.is_load &&
                     ((i_d_ctrl.rs_re && i_d_ctrl.rs == x_ctrl_q.rd) ||
                      (i_d_ctrl.rt_re && !i_d_ctrl.is_store && i_d_ctrl.rt == x_ctrl_q.rd) ||
                      i_d_ctrl.is_branch);  // branch waits for load nzp

   assign o_flush     = br_taken;
   assign o_stall     = load_use && !br_taken;  // D is squashed anyway
   assign o_br_target = alu_result;
   assign o_x_ctrl    = x_ctrl_q;
   assign o_x_insn    = x_insn_q;
   assign o_x_pc      = x_pc_q;
   assign o_x_result  = alu_result;
   assign o_x_rt_data = rt_byp;

endmodule

/* src/lc4_memwb.sv */
// --------------------
// memory and writeback
// --------------------
module lc4_memwb (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::ctrl_t    i_x_ctrl,
   input  lc4_pkg::word_t    i_x_insn,
   input  lc4_pkg::word_t    i_x_pc,
   input  lc4_pkg::word_t    i_x_result,
   input  lc4_pkg::word_t    i_x_rt_data,
   input  lc4_pkg::word_t    i_cur_dmem_data,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_towrite,
   lc4_fwd_if.src            fwd,
   output lc4_pkg::reg_sel_t o_rf_wsel,
   output logic              o_rf_we,
   output lc4_pkg::word_t    o_rf_wdata,
   output logic              o_wb_valid,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn
);

   lc4_pkg::ctrl_t m_ctrl_q;
   lc4_pkg::word_t m_insn_q;
   lc4_pkg::word_t m_pc_q;
   lc4_pkg::word_t m_result_q;
   lc4_pkg::word_t m_rt_q;
   lc4_pkg::ctrl_t w_ctrl_q;
   lc4_pkg::word_t w_insn_q;
   lc4_pkg::word_t w_pc_q;
   lc4_pkg::word_t w_result_q;
   lc4_pkg::word_t w_load_q;
   lc4_pkg::word_t w_data;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         m_ctrl_q <= '0;
         w_ctrl_q <= '0;
      end else begin
         m_ctrl_q <= i_x_ctrl;
         w_ctrl_q <= m_ctrl_q;
      end
   end

   always_ff @(posedge gwe) begin
      m_insn_q   <= i_x_insn;
      m_pc_q     <= i_x_pc;
      m_result_q <= i_x_result;
      m_rt_q     <= i_x_rt_data;
      w_insn_q   <= m_insn_q;
      w_pc_q     <= m_pc_q;
      w_result_q <= m_result_q;
      w_load_q   <= i_cur_dmem_data;  // only used when W holds a load
   end

   assign w_data = (w_ctrl_q.is_load) ? w_load_q : w_result_q;

   assign o_dmem_addr = (m_ctrl_q.is_load || m_ctrl_q.is_store) ? m_result_q : '0;
   assign o_dmem_we   = m_ctrl_q.is_store;
   // WM path, loaded value feeds the store right behind it
   assign o_dmem_towrite = (w_ctrl_q.is_load && w_ctrl_q.regfile_we &&
                            w_ctrl_q.rd == m_ctrl_q.rt) ? w_data : m_rt_q;

   // a load in M only has an address, never forward it
   assign fwd.m_rd   = m_ctrl_q.rd;
   assign fwd.m_we   = m_ctrl_q.regfile_we && !m_ctrl_q.is_load;
   assign fwd.m_data = m_result_q;
   assign fwd.w_rd   = w_ctrl_q.rd;
   assign fwd.w_we   = w_ctrl_q.regfile_we;
   assign fwd.w_data = w_data;

   assign o_rf_wsel  = w_ctrl_q.rd;
   assign o_rf_we    = w_ctrl_q.regfile_we;
   assign o_rf_wdata = w_data;
   assign o_wb_valid = w_ctrl_q.valid;  // bubbles and nops never retire
   assign o_wb_pc    = w_pc_q;
   assign o_wb_insn  = w_insn_q;

endmodule

/* src/lc4_processor.sv */
// --------------------
// lc4 pipeline top
// --------------------
module lc4_processor #(
   parameter lc4_pkg::word_t p_reset_pc = lc4_pkg::reset_pc
) (
   input  logic              gwe,
   input  logic              i_rst_n,
   output lc4_pkg::word_t    o_cur_pc,         // imem address
   input  lc4_pkg::word_t    i_cur_insn,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_towrite,
   input  lc4_pkg::word_t    i_cur_dmem_data,
   output logic              o_wb_valid,       // retirement strobe
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output logic              o_wb_rf_we,
   output lc4_pkg::reg_sel_t o_wb_rf_wsel,
   output lc4_pkg::word_t    o_wb_rf_data
);

   logic           stall;
   logic           flush;
   lc4_pkg::word_t br_target;
   lc4_pkg::word_t d_insn;
   lc4_pkg::word_t d_pc;
   lc4_pkg::ctrl_t d_ctrl;
   lc4_pkg::word_t rs_data;
   lc4_pkg::word_t rt_data;
   lc4_pkg::ctrl_t x_ctrl;
   lc4_pkg::word_t x_insn;
   lc4_pkg::word_t x_pc;
   lc4_pkg::word_t x_result;
   lc4_pkg::word_t x_rt_data;

   lc4_fwd_if fwd ();

   lc4_fetch #(.p_reset_pc(p_reset_pc)) i_lc4_fetch (
      .gwe, .i_rst_n,
      .i_stall     (stall),
      .i_flush     (flush),
      .i_br_target (br_target),
      .i_cur_insn, .o_cur_pc,
      .o_d_insn    (d_insn),
      .o_d_pc      (d_pc)
   );

   lc4_decoder i_lc4_decoder (.i_insn(d_insn), .o_ctrl(d_ctrl));

   // write port comes straight from the trace outputs
   lc4_regfile i_lc4_regfile (
      .gwe, .i_rst_n,
      .i_rs      (d_ctrl.rs),
      .i_rt      (d_ctrl.rt),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_rd      (o_wb_rf_wsel),
      .i_rd_we   (o_wb_rf_we),
      .i_wdata   (o_wb_rf_data)
   );

   lc4_execute i_lc4_execute (
      .gwe, .i_rst_n,
      .i_d_ctrl (d_ctrl), .i_d_insn (d_insn), .i_d_pc (d_pc),
      .i_rs_data (rs_data), .i_rt_data (rt_data),
      .i_cur_dmem_data, .fwd (fwd.exec),
      .o_stall (stall), .o_flush (flush), .o_br_target (br_target),
      .o_x_ctrl (x_ctrl), .o_x_insn (x_insn), .o_x_pc (x_pc),
      .o_x_result (x_result), .o_x_rt_data (x_rt_data)
   );

   lc4_memwb i_lc4_memwb (
      .gwe, .i_rst_n,
      .i_x_ctrl (x_ctrl), .i_x_insn (x_insn), .i_x_pc (x_pc),
      .i_x_result (x_result), .i_x_rt_data (x_rt_data),
      .i_cur_dmem_data, .o_dmem_addr, .o_dmem_we, .o_dmem_towrite,
      .fwd (fwd.src),
      .o_rf_wsel (o_wb_rf_wsel), .o_rf_we (o_wb_rf_we), .o_rf_wdata (o_wb_rf_data),
      .o_wb_valid, .o_wb_pc, .o_wb_insn
   );

endmodule

/* tb/lc4_assert.sv */
// --------------------
// pipeline assertions
// --------------------
module lc4_assert (
   input logic           gwe,
   input logic           i_rst_n,
   input logic           i_dmem_we,
   input logic           i_wb_valid,
   input logic           i_wb_rf_we,
   input logic           i_stall,     // load-use hold from execute
   input lc4_pkg::word_t i_cur_pc
);

   // registers are cleared by the first reset edge
   no_store_in_reset: assert property (@(posedge gwe) !i_rst_n |=> !i_dmem_we)
      else $error("dmem write enable high during reset");

   rf_we_needs_valid: assert property (@(posedge gwe) disable iff (!i_rst_n)
                                       i_wb_rf_we |-> i_wb_valid)
      else $error("register write from an instruction that does not retire");

   pc_held_on_stall: assert property (@(posedge gwe) disable iff (!i_rst_n)
                                      i_stall |=> $stable(i_cur_pc))
      else $error("pc moved during a load-use stall");

endmodule

bind lc4_processor lc4_assert i_lc4_assert (
   .gwe,
   .i_rst_n,
   .i_dmem_we  (o_dmem_we),
   .i_wb_valid (o_wb_valid),
   .i_wb_rf_we (o_wb_rf_we),
   .i_stall    (stall),
   .i_cur_pc   (o_cur_pc)
);

/* tb/tb_lc4.sv */
// --------------------
// lc4 pipeline testbench
// --------------------
module tb_lc4;

   typedef struct packed {
      lc4_pkg::word_t    pc;
      lc4_pkg::word_t    insn;
      logic              we;
      lc4_pkg::reg_sel_t rd;
      lc4_pkg::word_t    data;
   } retire_t;

   localparam lc4_pkg::word_t boot_pc = 16'h8200;  // imem base and first pc

   logic              gwe = 1'b0;
   logic              rst_n;
   lc4_pkg::word_t    cur_pc;
   lc4_pkg::word_t    cur_insn = '0;
   lc4_pkg::word_t    dmem_addr;
   logic              dmem_we;
   lc4_pkg::word_t    dmem_towrite;
   lc4_pkg::word_t    cur_dmem_data = '0;
   logic              wb_valid;
   lc4_pkg::word_t    wb_pc;
   lc4_pkg::word_t    wb_insn;
   logic              wb_rf_we;
   lc4_pkg::reg_sel_t wb_rf_wsel;
   lc4_pkg::word_t    wb_rf_data;

   lc4_pkg::word_t imem [0:65535];
   lc4_pkg::word_t dmem [0:65535];
   lc4_pkg::word_t ref_dmem [0:65535];  // model's own copy of data memory
   lc4_pkg::word_t prog [$];
   lc4_pkg::word_t prog_end;
   retire_t        exp_q [$];
   lc4_pkg::word_t exp_st_addr [$];
   lc4_pkg::word_t exp_st_data [$];
   lc4_pkg::word_t seen_st_addr [$];
   lc4_pkg::word_t seen_st_data [$];
   logic [31:0]    rng_state;
   int             err_count;
   int             timeout_count;

   lc4_processor #(.p_reset_pc(lc4_pkg::reset_pc)) i_lc4_processor (
      .gwe, .i_rst_n (rst_n),
      .o_cur_pc (cur_pc), .i_cur_insn (cur_insn),
      .o_dmem_addr (dmem_addr), .o_dmem_we (dmem_we), .o_dmem_towrite (dmem_towrite),
      .i_cur_dmem_data (cur_dmem_data),
      .o_wb_valid (wb_valid), .o_wb_pc (wb_pc), .o_wb_insn (wb_insn),
      .o_wb_rf_we (wb_rf_we), .o_wb_rf_wsel (wb_rf_wsel), .o_wb_rf_data (wb_rf_data)
   );

   always #4 gwe = ~gwe;

   // memories answer on the falling edge and a store lands before the read
   always @(negedge gwe) begin
      if (dmem_we === 1'b1) begin
         dmem[dmem_addr] = dmem_towrite;
         seen_st_addr.push_back(dmem_addr);
         seen_st_data.push_back(dmem_towrite);
      end
      cur_insn      = imem[cur_pc];
      cur_dmem_data = dmem[dmem_addr];
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic lc4_pkg::word_t fill_value(input lc4_pkg::word_t a);
      return a ^ {a[7:0], a[15:8]} ^ 16'h3c5a;
   endfunction

   // opcode 1111 is outside the kept subset, so these never retire
   function automatic lc4_pkg::word_t filler_insn(input lc4_pkg::word_t a);
      return {4'hf, a[11:0] ^ {8'h00, a[15:12]}};
   endfunction

   function automatic lc4_pkg::nzp_t nzp_from(input lc4_pkg::word_t v);
      if (v[15]) return 3'b100;
      if (v == 16'h0000) return 3'b010;
      return 3'b001;
   endfunction

   function automatic lc4_pkg::word_t const_insn(input lc4_pkg::reg_sel_t rd,
                                                input logic [8:0] imm);
      return {4'b1001, rd, imm};
   endfunction

   // add 0001/000, sub 0001/010, and 0101/000
   function automatic lc4_pkg::word_t alu_insn(input logic [3:0] op, input logic [2:0] sub,
                                              input lc4_pkg::reg_sel_t rd,
                                              input lc4_pkg::reg_sel_t rs,
                                              input lc4_pkg::reg_sel_t rt);
      return {op, rd, rs, sub, rt};
   endfunction

   function automatic lc4_pkg::word_t addi_insn(input lc4_pkg::reg_sel_t rd,
                                               input lc4_pkg::reg_sel_t rs,
                                               input logic [4:0] imm);
      return {4'b0001, rd, rs, 1'b1, imm};
   endfunction

   function automatic lc4_pkg::word_t ldr_insn(input lc4_pkg::reg_sel_t rd,
                                              input lc4_pkg::reg_sel_t rs,
                                              input logic [5:0] off);
      return {4'b0110, rd, rs, off};
   endfunction

   function automatic lc4_pkg::word_t str_insn(input lc4_pkg::reg_sel_t rt,
                                              input lc4_pkg::reg_sel_t rs,
                                              input logic [5:0] off);
      return {4'b0111, rt, rs, off};
   endfunction

   function automatic lc4_pkg::word_t br_insn(input lc4_pkg::nzp_t nzp, input logic [8:0] off);
      return {4'b0000, nzp, off};
   endfunction

   task automatic check_word(input string what, input lc4_pkg::word_t exp,
                             input lc4_pkg::word_t act);
      if (exp !== act) begin
         $display("[ERROR] %s expected %h actual %h", what, exp, act);
         err_count++;
      end
   endtask

   task automatic check_sel(input string what, input lc4_pkg::reg_sel_t exp,
                            input lc4_pkg::reg_sel_t act);
      if (exp !== act) begin
         $display("[ERROR] %s expected %0d actual %0d", what, exp, act);
         err_count++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[ERROR] %s expected %b actual %b", what, exp, act);
         err_count++;
      end
   endtask

   task automatic load_program();
      int a;
      for (a = 0; a < 65536; a++) begin
         imem[16'(a)]     = filler_insn(16'(a));
         dmem[16'(a)]     = fill_value(16'(a));
         ref_dmem[16'(a)] = fill_value(16'(a));
      end
      foreach (prog[i]) imem[boot_pc + 16'(i)] = prog[i];
      prog_end = boot_pc + 16'(prog.size());
   endtask

   // in-order ISA model that runs one instruction per step
   task automatic run_model();
      lc4_pkg::word_t    regs [8];
      lc4_pkg::word_t    pc, next_pc, insn, rs_v, result, addr;
      lc4_pkg::word_t    imm5, imm6, imm9;
      lc4_pkg::nzp_t     flags;
      lc4_pkg::reg_sel_t rd;
      logic              writes, valid;
      retire_t           r;
      int                i, steps;
      for (i = 0; i < 8; i++) regs[i] = '0;
      exp_q.delete();
      exp_st_addr.delete();
      exp_st_data.delete();
      pc    = boot_pc;
      flags = 3'b010;  // z after reset
      steps = 0;
      while (pc < prog_end && steps < 1000) begin
         insn    = imem[pc];
         rd      = insn[11:9];
         rs_v    = regs[insn[8:6]];
         imm5    = {{11{insn[4]}}, insn[4:0]};
         imm6    = {{10{insn[5]}}, insn[5:0]};
         imm9    = {{7{insn[8]}}, insn[8:0]};
         next_pc = pc + 16'd1;
         writes  = 1'b0;
         valid   = 1'b1;
         result  = '0;
         case (insn[15:12])
            4'b0000: begin  // rd field holds nzp here
               if (rd == 3'b000) valid = 1'b0;
               else if (|(rd & flags)) next_pc = pc + 16'd1 + imm9;
            end
            4'b0001: begin
               writes = 1'b1;
               if (insn[5]) result = rs_v + imm5;
               else if (insn[5:3] == 3'b000) result = rs_v + regs[insn[2:0]];
               else if (insn[5:3] == 3'b010) result = rs_v - regs[insn[2:0]];
               else {valid, writes} = 2'b00;
            end
            4'b0101: begin
               if (insn[5:3] == 3'b000) begin
                  result = rs_v & regs[insn[2:0]];
                  writes = 1'b1;
               end else begin
                  valid = 1'b0;
               end
            end
            4'b0110: begin
               result = ref_dmem[rs_v + imm6];
               writes = 1'b1;
            end
            4'b0111: begin
               addr           = rs_v + imm6;
               ref_dmem[addr] = regs[rd];
               exp_st_addr.push_back(addr);
               exp_st_data.push_back(regs[rd]);
            end
            4'b1001: begin
               result = imm9;
               writes = 1'b1;
            end
            default: valid = 1'b0;
         endcase
         if (writes) begin
            regs[rd] = result;
            flags    = nzp_from(result);
         end
         if (valid) begin
            r = '{pc: pc, insn: insn, we: writes, rd: rd, data: result};
            exp_q.push_back(r);
         end
         pc = next_pc;
         steps++;
      end
   endtask

   task automatic apply_reset();
      @(negedge gwe);
      rst_n = 1'b0;
      repeat (5) @(posedge gwe);
      @(negedge gwe);
      rst_n = 1'b1;
   endtask

   task automatic wait_retire(input string name, output logic seen);
      int cycles;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < 200) begin
         @(negedge gwe);
         cycles++;
         seen = wb_valid;
      end
      if (!seen) begin
         $display("timeout in %s: no retirement within 200 cycles", name);
         timeout_count++;
      end
   endtask

   // runs prog on the DUT and compares every retirement and store with the model
   task automatic run_program(input string name);
      logic    seen;
      retire_t r;
      int      drain;
      load_program();
      run_model();
      apply_reset();
      seen_st_addr.delete();
      seen_st_data.delete();
      foreach (exp_q[i]) begin
         r = exp_q[i];
         wait_retire(name, seen);
         if (!seen) return;
         check_word({name, ": pc"}, r.pc, wb_pc);
         check_word({name, ": insn"}, r.insn, wb_insn);
         check_bit({name, ": rf_we"}, r.we, wb_rf_we);
         if (r.we) begin
            check_sel({name, ": rd"}, r.rd, wb_rf_wsel);
            check_word({name, ": data"}, r.data, wb_rf_data);
         end
      end
      for (drain = 0; drain < 12; drain++) begin  // flushed and filler words stay quiet
         @(negedge gwe);
         if (wb_valid) begin
            $display("%s: unexpected retirement at pc %h", name, wb_pc);
            err_count++;
         end
      end
      if (seen_st_addr.size() != exp_st_addr.size()) begin
         $display("%s: %0d stores seen on the dmem port, %0d expected", name,
                  seen_st_addr.size(), exp_st_addr.size());
         err_count++;
      end else begin
         foreach (exp_st_addr[i]) begin
            check_word({name, ": store addr"}, exp_st_addr[i], seen_st_addr[i]);
            check_word({name, ": store data"}, exp_st_data[i], seen_st_data[i]);
         end
      end
   endtask

   task automatic reset_values();
      prog.delete();
      prog.push_back(const_insn(3'd1, 9'h005));
      load_program();
      apply_reset();
      check_word("reset: cur_pc", boot_pc, cur_pc);
      check_bit("reset: dmem_we", 1'b0, dmem_we);
      check_bit("reset: wb_valid", 1'b0, wb_valid);
   endtask

   task automatic alu_chain();
      prog.delete();
      prog.push_back(const_insn(3'd1, 9'h1f9));               // -7
      prog.push_back(const_insn(3'd2, 9'h00c));
      prog.push_back(alu_insn(4'b0001, 3'b000, 3'd3, 3'd1, 3'd2));  // WX and MX
      prog.push_back(alu_insn(4'b0001, 3'b010, 3'd4, 3'd3, 3'd1));
      prog.push_back(alu_insn(4'b0101, 3'b000, 3'd5, 3'd4, 3'd3));
      prog.push_back(addi_insn(3'd6, 3'd5, 5'h1d));
      prog.push_back(alu_insn(4'b0001, 3'b000, 3'd7, 3'd6, 3'd4));
      prog.push_back(alu_insn(4'b0001, 3'b010, 3'd1, 3'd7, 3'd7));
      prog.push_back(addi_insn(3'd2, 3'd1, 5'h0f));
      run_program("alu_chain");
   endtask

   task automatic load_store();
      prog.delete();
      prog.push_back(const_insn(3'd1, 9'h020));
      prog.push_back(ldr_insn(3'd2, 3'd1, 6'h03));
      prog.push_back(alu_insn(4'b0001, 3'b000, 3'd3, 3'd2, 3'd2));  // load-use stall
      prog.push_back(ldr_insn(3'd4, 3'd1, 6'h3e));
      prog.push_back(str_insn(3'd4, 3'd1, 6'h05));  // data via WM
      prog.push_back(ldr_insn(3'd5, 3'd1, 6'h05));
      prog.push_back(alu_insn(4'b0001, 3'b000, 3'd6, 3'd5, 3'd3));
      prog.push_back(alu_insn(4'b0001, 3'b000, 3'd7, 3'd2, 3'd4));
      prog.push_back(str_insn(3'd7, 3'd1, 6'h08));
      prog.push_back(ldr_insn(3'd2, 3'd1, 6'h08));
      prog.push_back(ldr_insn(3'd3, 3'd2, 6'h00));  // address from a load
      run_program("load_store");
   endtask

   task automatic branch_flags();
      prog.delete();
      prog.push_back(const_insn(3'd1, 9'h1ff));
      prog.push_back(br_insn(3'b100, 9'd1));        // taken on n
      prog.push_back(const_insn(3'd7, 9'd99));
      prog.push_back(br_insn(3'b011, 9'd1));
      prog.push_back(const_insn(3'd2, 9'd0));
      prog.push_back(br_insn(3'b010, 9'd1));
      prog.push_back(const_insn(3'd7, 9'd98));
      prog.push_back(const_insn(3'd3, 9'd4));
      prog.push_back(br_insn(3'b110, 9'd2));
      prog.push_back(br_insn(3'b001, 9'd1));
      prog.push_back(const_insn(3'd7, 9'd97));
      prog.push_back(const_insn(3'd1, 9'h040));
      prog.push_back(const_insn(3'd5, 9'd0));
      prog.push_back(str_insn(3'd5, 3'd1, 6'h00));
      prog.push_back(ldr_insn(3'd4, 3'd1, 6'h00));
      prog.push_back(br_insn(3'b010, 9'd1));        // right after the load
      prog.push_back(const_insn(3'd7, 9'd96));
      prog.push_back(const_insn(3'd5, 9'h1fb));
      prog.push_back(str_insn(3'd5, 3'd1, 6'h01));
      prog.push_back(ldr_insn(3'd4, 3'd1, 6'h01));
      prog.push_back(br_insn(3'b011, 9'd1));
      prog.push_back(br_insn(3'b100, 9'd1));
      prog.push_back(const_insn(3'd7, 9'd95));
      prog.push_back(const_insn(3'd6, 9'd9));
      prog.push_back(str_insn(3'd6, 3'd1, 6'h02));
      prog.push_back(ldr_insn(3'd4, 3'd1, 6'h02));
      prog.push_back(br_insn(3'b001, 9'd1));
      prog.push_back(const_insn(3'd7, 9'd94));
      prog.push_back(addi_insn(3'd6, 3'd4, 5'h01));
      run_program("branch_flags");
   endtask

   task automatic random_program();
      logic [31:0]       r;
      lc4_pkg::reg_sel_t rd, rs, rt;
      int                k;
      prog.delete();
      for (k = 0; k < 48; k++) begin
         r  = next_rand();
         rd = r[18:16];  // upper lcg bits are the better ones
         rs = r[21:19];
         rt = r[24:22];
         case (r[31:29])
            3'd0, 3'd1: prog.push_back(const_insn(rd, r[15:7]));
            3'd2:       prog.push_back(alu_insn(4'b0001, 3'b000, rd, rs, rt));
            3'd3:       prog.push_back(alu_insn(4'b0001, 3'b010, rd, rs, rt));
            3'd4:       prog.push_back(alu_insn(4'b0101, 3'b000, rd, rs, rt));
            3'd5:       prog.push_back(addi_insn(rd, rs, r[12:8]));
            default:    prog.push_back(br_insn(r[27:25], {7'd0, r[14:13]}));  // skip 0..3
         endcase
      end
      run_program("random_program");
   endtask

   initial begin
      rst_n         = 1'b0;
      rng_state     = 32'hd6dec1af;
      err_count     = 0;
      timeout_count = 0;
      reset_values();
      alu_chain();
      load_store();
      branch_flags();
      random_program();
      $display("summary: %0d errors, %0d timeouts", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
src/lc4_pkg.sv
src/lc4_fwd_if.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_alu.sv
src/lc4_fetch.sv
src/lc4_execute.sv
src/lc4_memwb.sv
src/lc4_processor.sv
tb/lc4_assert.sv
tb/tb_lc4.sv

/* run.sh */
#!/bin/sh
# build and run the lc4 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_lc4 \
   -Mdir obj_dir -o tb_lc4_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_lc4_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0
